// ==== Makefile ====
# Verilator build and run for the memory controller front end

VERILATOR       ?= verilator
TOP             ?= mem_ctrl_tb
SOURCES         ?= sources.f
OBJ_DIR         ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing --assert

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

# Rebuild when the file list or any listed source changes
$(SIM): $(SOURCES) $(shell cat $(SOURCES) 2>/dev/null)
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(SOURCES)

# Fails unless the pass line shows up in the simulation output
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'STATUS: PASS'

clean:
	rm -rf $(OBJ_DIR)

// ==== rtl/mem_ctrl_pkg.sv ====
`default_nettype none

package mem_ctrl_pkg;

  // ----------------------------------------
  // Geometry of the DRAM
  // ----------------------------------------
  localparam int NUM_BANKS  = 8;
  localparam int BANK_WIDTH = 3;             // log2 of NUM_BANKS
  localparam int PAGE_WIDTH = 12;            // Row address
  localparam int WORD_WIDTH = 8;             // Column address
  localparam int DATA_WIDTH = 32;

  // Row and column share one address bus
  localparam int ADDR_WIDTH = (PAGE_WIDTH > WORD_WIDTH) ? PAGE_WIDTH : WORD_WIDTH;

  // ----------------------------------------
  // DFI command {cs, cmd1, cmd0}
  // ----------------------------------------
  // Same code means different things in the page and read/write slots
  typedef logic [2:0] dfi_cmd_t;

  localparam dfi_cmd_t CMD_NOP         = 3'b000;
  localparam dfi_cmd_t CMD_PAGE_OPEN   = 3'b011;  // Page slot
  localparam dfi_cmd_t CMD_PAGE_CLOSE  = 3'b010;  // Page slot
  localparam dfi_cmd_t CMD_CACHE_READ  = 3'b010;  // Read/write slot
  localparam dfi_cmd_t CMD_CACHE_WRITE = 3'b011;  // Read/write slot

  // One queued request
  typedef struct packed {
    logic                  write;              // 1 = cache write
    logic [BANK_WIDTH-1:0] bank;
    logic [PAGE_WIDTH-1:0] page;
    logic [WORD_WIDTH-1:0] word;
    logic [DATA_WIDTH-1:0] data;               // Write data, ignored for reads
  } request_t;

  // A page slot plus the read/write slot right behind it
  typedef struct packed {
    dfi_cmd_t              page_cmd;           // Open, close or NOP
    dfi_cmd_t              rw_cmd;             // Read, write or NOP
    logic [BANK_WIDTH-1:0] bank;
    logic [PAGE_WIDTH-1:0] page;
    logic [WORD_WIDTH-1:0] word;
    logic [DATA_WIDTH-1:0] data;
  } slot_pair_t;

endpackage

`default_nettype wire

// ==== rtl/mem_ctrl_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_ctrl_top
  import mem_ctrl_pkg::*;
#(
  parameter int REQ_FIFO_DEPTH      = 8,
  parameter int REQ_FIFO_THRESHOLD  = REQ_FIFO_DEPTH - 2,    // Two requests still in flight
  parameter int PAIR_FIFO_DEPTH     = 4,
  parameter int PAIR_FIFO_THRESHOLD = PAIR_FIFO_DEPTH - 1
) (
  input  wire logic                  clk,
  input  wire logic                  reset,
  input  wire logic                  req_valid,
  input  wire logic                  req_write,
  input  wire logic [BANK_WIDTH-1:0] req_bank,
  input  wire logic [PAGE_WIDTH-1:0] req_page,
  input  wire logic [WORD_WIDTH-1:0] req_word,
  input  wire logic [DATA_WIDTH-1:0] req_data,
  output logic                       req_ready,
  input  wire logic                  init_done,
  output logic                       dfi_page_slot,
  output logic                       dfi_cs,
  output logic                       dfi_cmd1,
  output logic                       dfi_cmd0,
  output logic [BANK_WIDTH-1:0]      dfi_bank,
  output logic [ADDR_WIDTH-1:0]      dfi_addr,
  output logic [DATA_WIDTH-1:0]      dfi_data
);

  logic       req_valid_d1;
  request_t   req_d1;
  request_t   req_head;
  logic       req_empty;
  logic       req_almost_full;
  logic       req_read;
  slot_pair_t pair_data;
  slot_pair_t pair_head;
  logic       pair_write;
  logic       pair_read;
  logic       pair_empty;
  logic       pair_almost_full;

  // ----------------------------------------
  // Input stage and ready
  // ----------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      req_valid_d1 <= 1'b0;
      req_ready    <= 1'b0;
    end
    else
    begin
      req_valid_d1 <= req_valid;
      req_ready    <= !req_almost_full;   // One cycle behind the FIFO level
    end
  end

  always_ff @(posedge clk)
  begin
    req_d1 <= '{write: req_write, bank: req_bank, page: req_page,
                word: req_word, data: req_data};
  end

  request_fifo #(.DEPTH(REQ_FIFO_DEPTH), .ALMOST_FULL_THRESHOLD(REQ_FIFO_THRESHOLD),
                 .payload_t(request_t)) request_fifo_i (
    .clk(clk), .reset(reset),
    .write(req_valid_d1), .write_data(req_d1),
    .read(req_read), .read_data(req_head),
    .empty(req_empty), .almost_full(req_almost_full), .full()
  );

  // Requests to slot pairs
  page_tracker page_tracker_i (
    .clk(clk), .reset(reset),
    .req_empty(req_empty), .req_head(req_head), .pair_almost_full(pair_almost_full),
    .req_read(req_read), .pair_write(pair_write), .pair_data(pair_data)
  );

  request_fifo #(.DEPTH(PAIR_FIFO_DEPTH), .ALMOST_FULL_THRESHOLD(PAIR_FIFO_THRESHOLD),
                 .payload_t(slot_pair_t)) pair_fifo_i (
    .clk(clk), .reset(reset),
    .write(pair_write), .write_data(pair_data),
    .read(pair_read), .read_data(pair_head),
    .empty(pair_empty), .almost_full(pair_almost_full), .full()
  );

  phase_driver phase_driver_i (
    .clk(clk), .reset(reset), .init_done(init_done),
    .pair_empty(pair_empty), .pair_head(pair_head), .pair_read(pair_read),
    .dfi_page_slot(dfi_page_slot), .dfi_cs(dfi_cs), .dfi_cmd1(dfi_cmd1), .dfi_cmd0(dfi_cmd0),
    .dfi_bank(dfi_bank), .dfi_addr(dfi_addr), .dfi_data(dfi_data)
  );

endmodule

`default_nettype wire

// ==== rtl/page_tracker.sv ====
`timescale 1ns/100ps
`default_nettype none

module page_tracker
  import mem_ctrl_pkg::*;
(
  input  wire logic     clk,
  input  wire logic     reset,
  input  wire logic     req_empty,
  input  wire request_t req_head,
  input  wire logic     pair_almost_full,
  output logic          req_read,
  output logic          pair_write,
  output slot_pair_t    pair_data
);

  logic                  page_open [NUM_BANKS];   // Bank has a row open
  logic [PAGE_WIDTH-1:0] open_page [NUM_BANKS];   // Which row
  logic                  close_pending;           // Close sent, open still owed
  logic                  bank_open;
  logic                  page_hit;
  logic                  issue;
  dfi_cmd_t              page_cmd;
  dfi_cmd_t              rw_cmd;

  // ----------------------------------------
  // Page decision for the head request
  // ----------------------------------------
  assign bank_open = page_open[req_head.bank];
  assign page_hit  = bank_open && (open_page[req_head.bank] == req_head.page);
  assign issue     = !req_empty && !pair_almost_full;   // One pair per cycle

  always_comb
  begin
    rw_cmd   = req_head.write ? CMD_CACHE_WRITE : CMD_CACHE_READ;
    page_cmd = CMD_NOP;                                 // Hit
    if (close_pending || !bank_open)
      page_cmd = CMD_PAGE_OPEN;                         // Second half of a miss, or bank idle
    else if (!page_hit)
    begin
      page_cmd = CMD_PAGE_CLOSE;                        // Miss on open bank, close first
      rw_cmd   = CMD_NOP;
    end
  end

  assign pair_write = issue;
  assign req_read   = issue && (page_cmd != CMD_PAGE_CLOSE);  // Pop with the last pair

  always_comb
  begin
    pair_data.page_cmd = page_cmd;
    pair_data.rw_cmd   = rw_cmd;
    pair_data.bank     = req_head.bank;
    pair_data.page     = req_head.page;
    pair_data.word     = req_head.word;
    pair_data.data     = req_head.data;
  end

  // ----------------------------------------
  // Page table update
  // ----------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int b = 0; b < NUM_BANKS; b++)
        page_open[b] <= 1'b0;
      close_pending <= 1'b0;
    end
    else if (issue)
    begin
      if (page_cmd == CMD_PAGE_OPEN)
        page_open[req_head.bank] <= 1'b1;
      else if (page_cmd == CMD_PAGE_CLOSE)
        page_open[req_head.bank] <= 1'b0;
      close_pending <= (page_cmd == CMD_PAGE_CLOSE);
    end
  end

  always_ff @(posedge clk)
  begin
    if (issue && (page_cmd == CMD_PAGE_OPEN))
      open_page[req_head.bank] <= req_head.page;   // Row latched as it opens
  end

  no_double_open: assert property (@(posedge clk) disable iff (reset)
    (issue && (page_cmd == CMD_PAGE_OPEN)) |-> !page_open[req_head.bank])
    else $error("page_tracker: page open on a bank that is already open");

endmodule

`default_nettype wire

// ==== rtl/phase_driver.sv ====
`timescale 1ns/100ps
`default_nettype none

module phase_driver
  import mem_ctrl_pkg::*;
(
  input  wire logic              clk,
  input  wire logic              reset,
  input  wire logic              init_done,
  input  wire logic              pair_empty,
  input  wire slot_pair_t        pair_head,
  output logic                   pair_read,
  output logic                   dfi_page_slot,   // 1 = page slot, 0 = read/write slot
  output logic                   dfi_cs,
  output logic                   dfi_cmd1,
  output logic                   dfi_cmd0,
  output logic [BANK_WIDTH-1:0]  dfi_bank,
  output logic [ADDR_WIDTH-1:0]  dfi_addr,
  output logic [DATA_WIDTH-1:0]  dfi_data
);

  // One-hot, one state per bus cycle
  typedef enum logic [4:0] {
    WAIT         = 5'b00001,   // Init not done, bus idle
    PAGE_CMD     = 5'b00010,   // Page slot with a popped pair
    NOP_PAGE_CMD = 5'b00100,   // Page slot, nothing queued
    RW_CMD       = 5'b01000,   // Read/write slot of the held pair
    NOP_RW_CMD   = 5'b10000    // Read/write slot, nothing held
  } state_t;

  state_t     state;
  state_t     next_state;
  slot_pair_t held_pair;       // Pair popped in the last page slot
  dfi_cmd_t   dfi_cmd;

  // ----------------------------------------
  // State register
  // ----------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset)
      state <= WAIT;
    else
      state <= next_state;
  end

  // Decision for the page slot is made one cycle early, in the read/write slot.
  // Only this block pops the pair FIFO, so a pair seen here is still there next cycle
  always_comb
  begin
    case (state)
      WAIT, RW_CMD, NOP_RW_CMD:
      begin
        if (!init_done)
          next_state = WAIT;               // Stop only on a pair boundary
        else if (pair_empty)
          next_state = NOP_PAGE_CMD;
        else
          next_state = PAGE_CMD;
      end
      PAGE_CMD:     next_state = RW_CMD;
      NOP_PAGE_CMD: next_state = NOP_RW_CMD;
      default:      next_state = WAIT;     // Illegal encoding, resync
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (state == PAGE_CMD)
      held_pair <= pair_head;              // Kept for the read/write slot
  end

  // ----------------------------------------
  // DFI command bus
  // ----------------------------------------
  always_comb
  begin
    pair_read     = 1'b0;
    dfi_page_slot = 1'b0;
    dfi_cmd       = CMD_NOP;
    dfi_bank      = '0;
    dfi_addr      = '0;
    dfi_data      = '0;                    // Zero except in a cache write slot
    case (state)
      PAGE_CMD:
      begin
        pair_read     = 1'b1;              // Pop as the page slot goes out
        dfi_page_slot = 1'b1;
        dfi_cmd       = pair_head.page_cmd;
        dfi_bank      = pair_head.bank;
        dfi_addr      = ADDR_WIDTH'(pair_head.page);
      end
      NOP_PAGE_CMD:
      begin
        dfi_page_slot = 1'b1;
      end
      RW_CMD:
      begin
        dfi_cmd  = held_pair.rw_cmd;       // NOP behind a page close
        dfi_bank = held_pair.bank;
        dfi_addr = ADDR_WIDTH'(held_pair.word);
        if (held_pair.rw_cmd == CMD_CACHE_WRITE)
          dfi_data = held_pair.data;
      end
      default:
      begin
        dfi_cmd = CMD_NOP;                 // WAIT and NOP_RW_CMD
      end
    endcase
  end

  assign {dfi_cs, dfi_cmd1, dfi_cmd0} = dfi_cmd;

  // A live read/write command needs a pair popped in the slot before
  rw_needs_pair: assert property (@(posedge clk) disable iff (reset)
    (dfi_cs && !dfi_page_slot) |-> $past(pair_read))
    else $error("phase_driver: read/write command without a held pair");

endmodule

`default_nettype wire

// ==== rtl/request_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module request_fifo #(
  parameter int  DEPTH                 = 8,
  parameter int  ALMOST_FULL_THRESHOLD = 6,
  parameter type payload_t             = logic
) (
  input  wire logic     clk,
  input  wire logic     reset,
  input  wire logic     write,
  input  wire payload_t write_data,
  input  wire logic     read,
  output payload_t      read_data,           // Head entry, valid while !empty
  output logic          empty,
  output logic          almost_full,
  output logic          full
);

  localparam int PTR_WIDTH   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int COUNT_WIDTH = $clog2(DEPTH + 1);

  payload_t               mem [DEPTH];
  logic [PTR_WIDTH-1:0]   wr_ptr;
  logic [PTR_WIDTH-1:0]   rd_ptr;
  logic [COUNT_WIDTH-1:0] count;             // Entries held

  // Wrap at DEPTH, depth need not be a power of two
  function automatic logic [PTR_WIDTH-1:0] ptr_next(input logic [PTR_WIDTH-1:0] ptr);
    if (ptr == PTR_WIDTH'(DEPTH - 1))
      return '0;
    else
      return ptr + 1'b1;
  endfunction

  // ----------------------------------------
  // Pointers and fill count
  // ----------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (write)
        wr_ptr <= ptr_next(wr_ptr);
      if (read)
        rd_ptr <= ptr_next(rd_ptr);
      case ({write, read})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;           // Both or neither, level unchanged
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (write)
      mem[wr_ptr] <= write_data;
  end

  assign read_data   = mem[rd_ptr];          // Show-ahead
  assign empty       = (count == '0);
  assign full        = (count == COUNT_WIDTH'(DEPTH));
  assign almost_full = (count >= COUNT_WIDTH'(ALMOST_FULL_THRESHOLD));

  // Writer and reader live outside, they must respect the flags
  no_overflow: assert property (@(posedge clk) disable iff (reset) write |-> !full)
    else $error("request_fifo: write while full");
  no_underflow: assert property (@(posedge clk) disable iff (reset) read |-> !empty)
    else $error("request_fifo: read while empty");

endmodule

`default_nettype wire

// ==== sources.f ====
rtl/mem_ctrl_pkg.sv
rtl/request_fifo.sv
rtl/page_tracker.sv
rtl/phase_driver.sv
rtl/mem_ctrl_top.sv
verification/mem_ctrl_tb.sv

// ==== verification/mem_ctrl_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_ctrl_tb
  import mem_ctrl_pkg::*;
();

  localparam int CLK_PERIOD      = 40;
  localparam int MAX_BURST       = 40;                  // Cap on the random burst
  localparam int TOTAL_REQS      = 6 + MAX_BURST;       // Directed plus burst
  localparam int WATCHDOG_CYCLES = TOTAL_REQS * 8 + 200;

  logic                  clk;
  logic                  reset;
  logic                  req_valid;
  logic                  req_write;
  logic [BANK_WIDTH-1:0] req_bank;
  logic [PAGE_WIDTH-1:0] req_page;
  logic [WORD_WIDTH-1:0] req_word;
  logic [DATA_WIDTH-1:0] req_data;
  logic                  req_ready;
  logic                  init_done;
  logic                  dfi_page_slot;
  logic                  dfi_cs;
  logic                  dfi_cmd1;
  logic                  dfi_cmd0;
  logic [BANK_WIDTH-1:0] dfi_bank;
  logic [ADDR_WIDTH-1:0] dfi_addr;
  logic [DATA_WIDTH-1:0] dfi_data;

  // Reference page table and expected pairs in bus order
  logic                  model_open [NUM_BANKS];
  logic [PAGE_WIDTH-1:0] model_page [NUM_BANKS];
  slot_pair_t            exp_q [$];

  string      test_name;
  int         value_errors;
  int         other_errors;
  logic [31:0] rng;
  slot_pair_t page_obs;                                 // Last page slot seen
  slot_pair_t rw_obs;
  slot_pair_t exp_pair;
  logic       page_seen;
  logic       slot_prev;
  logic       init_prev;

  mem_ctrl_top dut_i (
    .clk(clk), .reset(reset),
    .req_valid(req_valid), .req_write(req_write), .req_bank(req_bank),
    .req_page(req_page), .req_word(req_word), .req_data(req_data),
    .req_ready(req_ready), .init_done(init_done),
    .dfi_page_slot(dfi_page_slot), .dfi_cs(dfi_cs), .dfi_cmd1(dfi_cmd1),
    .dfi_cmd0(dfi_cmd0), .dfi_bank(dfi_bank), .dfi_addr(dfi_addr), .dfi_data(dfi_data)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  // ----------------------------------------
  // Compare tasks
  // ----------------------------------------
  task automatic report_mismatch(input string what, input logic [63:0] exp,
                                 input logic [63:0] act);
    value_errors++;
    $display("error %s: %s expected %0h actual %0h", test_name, what, exp, act);
  endtask

  task automatic compare_bit(input string what, input logic exp, input logic act);
    if (act !== exp)
      report_mismatch(what, 64'(exp), 64'(act));
  endtask

  task automatic compare_cmd(input string what, input dfi_cmd_t exp, input dfi_cmd_t act);
    if (act !== exp)
      report_mismatch(what, 64'(exp), 64'(act));
  endtask

  // One half of a pair, the page slot or the read/write slot
  task automatic compare_slot(input string what, input logic page_half,
                              input slot_pair_t exp, input slot_pair_t act);
    dfi_cmd_t              exp_cmd;
    dfi_cmd_t              act_cmd;
    logic [DATA_WIDTH-1:0] exp_data;
    exp_cmd  = page_half ? exp.page_cmd : exp.rw_cmd;
    act_cmd  = page_half ? act.page_cmd : act.rw_cmd;
    exp_data = (!page_half && exp.rw_cmd == CMD_CACHE_WRITE) ? exp.data : '0;
    compare_cmd({what, " cmd"}, exp_cmd, act_cmd);
    if (exp_cmd != CMD_NOP)                             // Bank and address only matter with a command
    begin
      if (act.bank !== exp.bank)
        report_mismatch({what, " bank"}, 64'(exp.bank), 64'(act.bank));
      if (page_half && act.page !== exp.page)
        report_mismatch({what, " page"}, 64'(exp.page), 64'(act.page));
      if (!page_half && act.word !== exp.word)
        report_mismatch({what, " word"}, 64'(exp.word), 64'(act.word));
    end
    if (act.data !== exp_data)
      report_mismatch({what, " data"}, 64'(exp_data), 64'(act.data));
  endtask

  // ----------------------------------------
  // Reference model and request driving
  // ----------------------------------------
  task automatic expand_request(input request_t req);
    dfi_cmd_t   rw;
    slot_pair_t pair;
    rw   = req.write ? CMD_CACHE_WRITE : CMD_CACHE_READ;
    pair = '{page_cmd: CMD_NOP, rw_cmd: rw, bank: req.bank, page: req.page,
             word: req.word, data: req.data};
    if (model_open[req.bank] && model_page[req.bank] == req.page)
      exp_q.push_back(pair);                            // Hit
    else
    begin
      if (model_open[req.bank])                         // Miss, close the old row first
      begin
        pair.page_cmd = CMD_PAGE_CLOSE;
        pair.rw_cmd   = CMD_NOP;
        exp_q.push_back(pair);
        pair.rw_cmd   = rw;
      end
      pair.page_cmd = CMD_PAGE_OPEN;
      exp_q.push_back(pair);
      model_open[req.bank] = 1'b1;
      model_page[req.bank] = req.page;
    end
  endtask

  // Drives one request for the current cycle
  task automatic offer_request(input logic write, input logic [BANK_WIDTH-1:0] bank,
                               input logic [PAGE_WIDTH-1:0] page,
                               input logic [WORD_WIDTH-1:0] word,
                               input logic [DATA_WIDTH-1:0] data);
    req_valid = 1'b1;
    req_write = write;
    req_bank  = bank;
    req_page  = page;
    req_word  = word;
    req_data  = data;
    expand_request('{write: write, bank: bank, page: page, word: word, data: data});
  endtask

  task automatic send_request(input logic write, input logic [BANK_WIDTH-1:0] bank,
                              input logic [PAGE_WIDTH-1:0] page,
                              input logic [WORD_WIDTH-1:0] word,
                              input logic [DATA_WIDTH-1:0] data);
    int waited;
    waited = 0;
    @(posedge clk);
    #2;
    while (!req_ready && waited < 50)
    begin
      @(posedge clk);
      #2;
      waited++;
    end
    if (!req_ready)
    begin
      other_errors++;
      $display("%s: req_ready stayed low, request not sent", test_name);
    end
    else
    begin
      offer_request(write, bank, page, word, data);
      @(posedge clk);
      #2;
      req_valid = 1'b0;
    end
  endtask

  task automatic wait_drained(input int limit);
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0 && cycles < limit)
    begin
      @(posedge clk);
      cycles++;
    end
    if (exp_q.size() != 0)
    begin
      other_errors++;
      $display("%s: %0d expected pairs never appeared on the bus", test_name, exp_q.size());
      exp_q.delete();
    end
    repeat (2) @(posedge clk);
  endtask

  // ----------------------------------------
  // Bus monitor, mid-cycle where outputs are stable
  // ----------------------------------------
  always @(negedge clk)
  begin
    if (reset)
      page_seen = 1'b0;
    else
    begin
      if (!init_done)
        compare_bit("dfi_cs before init_done", 1'b0, dfi_cs);
      if (init_prev && init_done && dfi_page_slot == slot_prev)
      begin
        other_errors++;
        $display("%s: dfi_page_slot did not toggle", test_name);
      end
      if (dfi_page_slot)
      begin
        page_seen = 1'b1;
        page_obs  = '{page_cmd: {dfi_cs, dfi_cmd1, dfi_cmd0}, rw_cmd: CMD_NOP,
                      bank: dfi_bank, page: dfi_addr[PAGE_WIDTH-1:0], word: '0,
                      data: dfi_data};
      end
      else if (page_seen)                               // Read/write slot closes the pair
      begin
        page_seen = 1'b0;
        rw_obs    = '{page_cmd: CMD_NOP, rw_cmd: {dfi_cs, dfi_cmd1, dfi_cmd0},
                      bank: dfi_bank, page: '0, word: dfi_addr[WORD_WIDTH-1:0],
                      data: dfi_data};
        if (page_obs.page_cmd == CMD_NOP && rw_obs.rw_cmd == CMD_NOP)
        begin
          compare_slot("idle page slot", 1'b1, '0, page_obs);  // Data must be zero
          compare_slot("idle rw slot", 1'b0, '0, rw_obs);
        end
        else if (exp_q.size() == 0)
        begin
          other_errors++;
          $display("%s: command on the bus with no request outstanding", test_name);
        end
        else
        begin
          exp_pair = exp_q.pop_front();
          compare_slot("page slot", 1'b1, exp_pair, page_obs);
          compare_slot("rw slot", 1'b0, exp_pair, rw_obs);
        end
      end
    end
    slot_prev = dfi_page_slot;
    init_prev = init_done && !reset;
  end

  // ----------------------------------------
  // Directed tests
  // ----------------------------------------
  task automatic test_init_hold();
    int waited;
    test_name = "init_hold";
    compare_bit("req_ready after reset", 1'b0, req_ready);
    compare_bit("dfi_cs after reset", 1'b0, dfi_cs);
    compare_bit("dfi_page_slot after reset", 1'b0, dfi_page_slot);
    waited = 0;
    while (!req_ready && waited < 4)
    begin
      @(posedge clk);
      #2;
      waited++;
    end
    if (!req_ready)
    begin
      other_errors++;
      $display("%s: req_ready did not rise after reset", test_name);
    end
    send_request(1'b1, 3'd2, 12'h012, 8'h05, 32'hcafe_0001);  // Held until init_done
    repeat (10) @(posedge clk);
    #2;
    init_done = 1'b1;
    wait_drained(40);
  endtask

  task automatic test_closed_bank();
    test_name = "closed_bank";
    send_request(1'b0, 3'd5, 12'h300, 8'h21, 32'h1234_5678);
    wait_drained(40);
  endtask

  task automatic test_page_hit();
    test_name = "page_hit";
    send_request(1'b1, 3'd5, 12'h300, 8'h22, 32'h0bad_f00d);
    wait_drained(40);
  endtask

  task automatic test_page_miss();
    test_name = "page_miss";
    send_request(1'b0, 3'd5, 12'h0a1, 8'h7f, 32'hffff_ffff);  // Close then open
    wait_drained(40);
  endtask

  task automatic test_write_data();
    test_name = "write_data";
    rng = xorshift(rng);
    send_request(1'b1, 3'd1, 12'h007, 8'h10, rng);
    send_request(1'b0, 3'd1, 12'h007, 8'h11, 32'h5a5a_5a5a);  // Read shows zero data
    wait_drained(40);
  endtask

  task automatic test_random_burst();
    logic [31:0] r;
    int          n;
    test_name = "random_burst";
    n = 0;
    @(posedge clk);
    #2;
    while (req_ready && n < MAX_BURST)
    begin
      rng = xorshift(rng);
      r   = rng;
      rng = xorshift(rng);
      offer_request(r[0], r[3:1], {10'b0, r[5:4]}, r[13:6], rng);  // Few pages, many hits
      n++;
      @(posedge clk);
      #2;
    end
    req_valid = 1'b0;
    if (req_ready)
    begin
      other_errors++;
      $display("%s: req_ready did not drop during the burst", test_name);
    end
    wait_drained(MAX_BURST * 8);
  endtask

  // ----------------------------------------
  // Run control
  // ----------------------------------------
  initial
  begin
    clk       = 1'b0;
    reset     = 1'b1;
    req_valid = 1'b0;
    req_write = 1'b0;
    req_bank  = '0;
    req_page  = '0;
    req_word  = '0;
    req_data  = '0;
    init_done = 1'b0;
    rng       = 32'h4b25;
    page_seen = 1'b0;
    slot_prev = 1'b0;
    init_prev = 1'b0;
    value_errors = 0;
    other_errors = 0;
    test_name = "reset";
    for (int b = 0; b < NUM_BANKS; b++)
    begin
      model_open[b] = 1'b0;
      model_page[b] = '0;
    end
    repeat (4) @(posedge clk);
    #2;
    reset = 1'b0;
    test_init_hold();
    test_closed_bank();
    test_page_hit();
    test_page_miss();
    test_write_data();
    test_random_burst();
    $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog: run did not finish in %0d cycles, stopped in %s",
             WATCHDOG_CYCLES, test_name);
    $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire
